// File: rtl/isa_pkg.sv
package isa_pkg;

    typedef logic [63:0] xlen_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [63:0] pc_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B      // lui
    } alu_op_t;

    typedef enum logic [1:0] {
        FWD_RF,
        FWD_EXE,
        FWD_WB
    } fwd_sel_t;

    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

    localparam funct3_t F3_ADD  = 3'b000;   // add, sub, addi
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;   // srl, sra
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    localparam instr_t INSTR_EBREAK = {12'h001, 5'd0, 3'b000, 5'd0, OPC_SYSTEM};

endpackage

// File: rtl/wb_pkg.sv
package wb_pkg;

    typedef logic [31:0] wb_addr_t;    // byte address
    typedef logic [31:0] wb_data_t;

endpackage

// File: rtl/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit
    import isa_pkg::*, wb_pkg::*;
#(
    parameter pc_t RESET_PC = 64'h0000_0000_8000_0000
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     stop_fetch_i,
    output logic     wb_cyc_o,
    output logic     wb_stb_o,
    output logic     wb_we_o,
    output wb_addr_t wb_adr_o,
    input  wb_data_t wb_dat_i,
    input  logic     wb_ack_i,
    output logic     f_valid_o,
    output instr_t   f_instr_o,
    output pc_t      f_pc_o
);
    pc_t  pc_q;
    logic cyc_q;
    logic take;

    assign take     = cyc_q & wb_ack_i;
    assign wb_cyc_o = cyc_q;
    assign wb_stb_o = cyc_q;
    assign wb_we_o  = 1'b0;         // read only master
    assign wb_adr_o = pc_q[31:0];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            cyc_q     <= 1'b0;
            pc_q      <= RESET_PC;
            f_valid_o <= 1'b0;
        end else begin
            if (!cyc_q || wb_ack_i) begin
                cyc_q <= !stop_fetch_i;   // an open cycle runs to its ack
            end
            if (take) begin
                pc_q <= pc_q + 64'd4;
            end
            f_valid_o <= take & !stop_fetch_i;   // word acked beside ebreak is dropped
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            f_instr_o <= wb_dat_i;
            f_pc_o    <= pc_q;
        end
    end

endmodule

// File: rtl/pipeline_ctrl.sv
`timescale 1ns/100ps

module pipeline_ctrl
    import isa_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     f_valid_i,
    input  instr_t   d_instr_i,
    input  reg_idx_t d_rs1_i,
    input  reg_idx_t d_rs2_i,
    input  reg_idx_t e_rd_i,
    input  reg_idx_t w_rd_i,
    input  logic     e_we_i,
    input  logic     w_we_i,
    output logic     d_valid_o,
    output logic     e_valid_o,
    output logic     w_valid_o,
    output fwd_sel_t fwd_a_o,
    output fwd_sel_t fwd_b_o,
    output logic     stop_fetch_o,
    output logic     halt_o
);
    typedef enum logic [1:0] {
        ST_RUN,
        ST_DRAIN,
        ST_HALTED
    } state_t;

    state_t state_q;
    logic   ebreak_d;
    logic   e_live;
    logic   w_live;

    assign d_valid_o    = f_valid_i & (state_q == ST_RUN);
    assign ebreak_d     = d_valid_o & (d_instr_i == INSTR_EBREAK);
    assign stop_fetch_o = ebreak_d | (state_q != ST_RUN);
    assign halt_o       = (state_q == ST_HALTED);

    // x0 as destination never forwards
    assign e_live = e_valid_o & e_we_i & (e_rd_i != 5'd0);
    assign w_live = w_valid_o & w_we_i & (w_rd_i != 5'd0);

    // execute result wins, it is the younger producer
    assign fwd_a_o = (e_live && d_rs1_i == e_rd_i) ? FWD_EXE :
                     (w_live && d_rs1_i == w_rd_i) ? FWD_WB : FWD_RF;
    assign fwd_b_o = (e_live && d_rs2_i == e_rd_i) ? FWD_EXE :
                     (w_live && d_rs2_i == w_rd_i) ? FWD_WB : FWD_RF;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q   <= ST_RUN;
            e_valid_o <= 1'b0;
            w_valid_o <= 1'b0;
        end else begin
            e_valid_o <= d_valid_o;
            w_valid_o <= e_valid_o;
            case (state_q)
                ST_RUN: begin
                    if (ebreak_d) begin
                        state_q <= ST_DRAIN;
                    end
                end
                ST_DRAIN: begin
                    if (e_valid_o) begin
                        state_q <= ST_HALTED;   // ebreak retires next cycle
                    end
                end
                default: state_q <= ST_HALTED;
            endcase
        end
    end

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/100ps

module decode_stage
    import isa_pkg::*;
(
    input  instr_t   d_instr_i,
    input  pc_t      d_pc_i,
    input  xlen_t    rf_a_i,
    input  xlen_t    rf_b_i,
    input  xlen_t    e_result_i,
    input  xlen_t    w_result_i,
    input  fwd_sel_t fwd_a_i,
    input  fwd_sel_t fwd_b_i,
    output reg_idx_t rs1_o,
    output reg_idx_t rs2_o,
    output xlen_t    op_a_o,
    output xlen_t    op_b_o,
    output alu_op_t  alu_op_o,
    output reg_idx_t rd_o,
    output logic     we_o,
    output pc_t      pc_o,
    output instr_t   instr_o
);
    opcode_t    opcode;
    funct3_t    funct3;
    logic [6:0] funct7;
    xlen_t      imm_i;
    xlen_t      imm_u;
    xlen_t      rs2_val;
    logic       legal;

    function automatic xlen_t fwd_mux(input fwd_sel_t sel, input xlen_t rf_val,
                                      input xlen_t e_val, input xlen_t w_val);
        case (sel)
            FWD_EXE: return e_val;
            FWD_WB:  return w_val;
            default: return rf_val;
        endcase
    endfunction

    assign opcode  = d_instr_i[6:0];
    assign rd_o    = d_instr_i[11:7];
    assign funct3  = d_instr_i[14:12];
    assign rs1_o   = d_instr_i[19:15];
    assign rs2_o   = d_instr_i[24:20];
    assign funct7  = d_instr_i[31:25];
    assign imm_i   = {{52{d_instr_i[31]}}, d_instr_i[31:20]};
    assign imm_u   = {{32{d_instr_i[31]}}, d_instr_i[31:12], 12'b0};
    assign op_a_o  = fwd_mux(fwd_a_i, rf_a_i, e_result_i, w_result_i);
    assign rs2_val = fwd_mux(fwd_b_i, rf_b_i, e_result_i, w_result_i);
    assign we_o    = legal & (rd_o != 5'd0);
    assign pc_o    = d_pc_i;
    assign instr_o = d_instr_i;

    always_comb begin
        op_b_o = rs2_val;
        legal  = 1'b0;
        case (funct3)
            F3_ADD:  alu_op_o = ALU_ADD;
            F3_SLL:  alu_op_o = ALU_SLL;
            F3_SLT:  alu_op_o = ALU_SLT;
            F3_SLTU: alu_op_o = ALU_SLTU;
            F3_XOR:  alu_op_o = ALU_XOR;
            F3_SR:   alu_op_o = funct7[5] ? ALU_SRA : ALU_SRL;
            F3_OR:   alu_op_o = ALU_OR;
            default: alu_op_o = ALU_AND;
        endcase
        if (opcode == OPC_OP) begin
            legal = (funct7 == 7'h00) ||
                    (funct7 == 7'h20 && (funct3 == F3_ADD || funct3 == F3_SR));
            if (funct7[5] && funct3 == F3_ADD) begin
                alu_op_o = ALU_SUB;
            end
        end else if (opcode == OPC_OP_IMM) begin
            op_b_o = imm_i;     // shamt sits in imm[5:0]
            if (funct3 == F3_SLL) begin
                legal = (d_instr_i[31:26] == 6'b000000);
            end else if (funct3 == F3_SR) begin
                legal = (d_instr_i[31:26] == 6'b000000) || (d_instr_i[31:26] == 6'b010000);
            end else begin
                legal = 1'b1;
            end
        end else if (opcode == OPC_LUI) begin
            op_b_o   = imm_u;
            alu_op_o = ALU_PASS_B;
            legal    = 1'b1;
        end
    end

endmodule

// File: rtl/alu_stage.sv
`timescale 1ns/100ps

module alu_stage
    import isa_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     d_valid_i,
    input  xlen_t    op_a_i,
    input  xlen_t    op_b_i,
    input  alu_op_t  alu_op_i,
    input  reg_idx_t rd_i,
    input  logic     we_i,
    input  pc_t      pc_i,
    input  instr_t   instr_i,
    output xlen_t    e_result_o,
    output reg_idx_t e_rd_o,
    output logic     e_we_o,
    output pc_t      e_pc_o,
    output instr_t   e_instr_o
);
    xlen_t      a_q;
    xlen_t      b_q;
    alu_op_t    op_q;
    logic [5:0] shamt;

    assign shamt = b_q[5:0];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            e_we_o <= 1'b0;
        end else begin
            e_we_o <= d_valid_i & we_i;     // bubble never writes
        end
    end

    always_ff @(posedge clk) begin
        a_q       <= op_a_i;
        b_q       <= op_b_i;
        op_q      <= alu_op_i;
        e_rd_o    <= rd_i;
        e_pc_o    <= pc_i;
        e_instr_o <= instr_i;
    end

    always_comb begin
        case (op_q)
            ALU_ADD:  e_result_o = a_q + b_q;
            ALU_SUB:  e_result_o = a_q - b_q;
            ALU_SLL:  e_result_o = a_q << shamt;
            ALU_SLT:  e_result_o = {63'd0, $signed(a_q) < $signed(b_q)};
            ALU_SLTU: e_result_o = {63'd0, a_q < b_q};
            ALU_XOR:  e_result_o = a_q ^ b_q;
            ALU_SRL:  e_result_o = a_q >> shamt;
            ALU_SRA:  e_result_o = xlen_t'($signed(a_q) >>> shamt);
            ALU_OR:   e_result_o = a_q | b_q;
            ALU_AND:  e_result_o = a_q & b_q;
            default:  e_result_o = b_q;     // lui
        endcase
    end

endmodule

// File: rtl/writeback_regfile.sv
`timescale 1ns/100ps

module writeback_regfile
    import isa_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     e_valid_i,
    input  xlen_t    e_result_i,
    input  reg_idx_t e_rd_i,
    input  logic     e_we_i,
    input  pc_t      e_pc_i,
    input  instr_t   e_instr_i,
    input  reg_idx_t ra_i,
    input  reg_idx_t rb_i,
    output xlen_t    rf_a_o,
    output xlen_t    rf_b_o,
    output xlen_t    w_result_o,
    output reg_idx_t w_rd_o,
    output logic     w_we_o,
    output logic     retire_valid_o,
    output pc_t      retire_pc_o,
    output instr_t   retire_instr_o,
    output reg_idx_t retire_rd_o,
    output xlen_t    retire_data_o
);
    xlen_t  regs [32];
    logic   w_valid_q;
    pc_t    w_pc_q;
    instr_t w_instr_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            w_valid_q <= 1'b0;
            w_we_o    <= 1'b0;
        end else begin
            w_valid_q <= e_valid_i;
            w_we_o    <= e_valid_i & e_we_i;
        end
    end

    always_ff @(posedge clk) begin
        w_rd_o     <= e_we_i ? e_rd_i : 5'd0;       // no write retires as rd 0
        w_result_o <= e_we_i ? e_result_i : 64'd0;
        w_pc_q     <= e_pc_i;
        w_instr_q  <= e_instr_i;
    end

    always_ff @(posedge clk) begin
        if (w_valid_q && w_we_o && w_rd_o != 5'd0) begin
            regs[w_rd_o] <= w_result_o;
        end
    end

    assign rf_a_o = (ra_i == 5'd0) ? 64'd0 : regs[ra_i];
    assign rf_b_o = (rb_i == 5'd0) ? 64'd0 : regs[rb_i];

    assign retire_valid_o = w_valid_q;
    assign retire_pc_o    = w_pc_q;
    assign retire_instr_o = w_instr_q;
    assign retire_rd_o    = w_rd_o;
    assign retire_data_o  = w_result_o;

endmodule

// File: rtl/rv_alu_core.sv
`timescale 1ns/100ps

module rv_alu_core
    import isa_pkg::*, wb_pkg::*;
#(
    parameter pc_t RESET_PC = 64'h0000_0000_8000_0000
) (
    input  logic     clk,
    input  logic     rst_n_i,
    output logic     wb_cyc_o,
    output logic     wb_stb_o,
    output logic     wb_we_o,
    output wb_addr_t wb_adr_o,
    input  wb_data_t wb_dat_i,
    input  logic     wb_ack_i,
    output logic     retire_valid_o,
    output pc_t      retire_pc_o,
    output instr_t   retire_instr_o,
    output reg_idx_t retire_rd_o,
    output xlen_t    retire_data_o,
    output logic     halt_o
);
    logic     f_valid;
    instr_t   f_instr;
    pc_t      f_pc;
    logic     d_valid;
    logic     e_valid;
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;
    logic     stop_fetch;
    reg_idx_t rs1;
    reg_idx_t rs2;
    xlen_t    op_a;
    xlen_t    op_b;
    alu_op_t  alu_op;
    reg_idx_t d_rd;
    logic     d_we;
    pc_t      d_pc;
    instr_t   d_instr;
    xlen_t    e_result;
    reg_idx_t e_rd;
    logic     e_we;
    pc_t      e_pc;
    instr_t   e_instr;
    xlen_t    rf_a;
    xlen_t    rf_b;
    xlen_t    w_result;
    reg_idx_t w_rd;
    logic     w_we;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .stop_fetch_i (stop_fetch),
        .wb_cyc_o     (wb_cyc_o),
        .wb_stb_o     (wb_stb_o),
        .wb_we_o      (wb_we_o),
        .wb_adr_o     (wb_adr_o),
        .wb_dat_i     (wb_dat_i),
        .wb_ack_i     (wb_ack_i),
        .f_valid_o    (f_valid),
        .f_instr_o    (f_instr),
        .f_pc_o       (f_pc)
    );

    pipeline_ctrl u_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .f_valid_i    (f_valid),
        .d_instr_i    (f_instr),
        .d_rs1_i      (rs1),
        .d_rs2_i      (rs2),
        .e_rd_i       (e_rd),
        .w_rd_i       (w_rd),
        .e_we_i       (e_we),
        .w_we_i       (w_we),
        .d_valid_o    (d_valid),
        .e_valid_o    (e_valid),
        .w_valid_o    (),               // only needed inside ctrl
        .fwd_a_o      (fwd_a),
        .fwd_b_o      (fwd_b),
        .stop_fetch_o (stop_fetch),
        .halt_o       (halt_o)
    );

    decode_stage u_decode (
        .d_instr_i  (f_instr),
        .d_pc_i     (f_pc),
        .rf_a_i     (rf_a),
        .rf_b_i     (rf_b),
        .e_result_i (e_result),
        .w_result_i (w_result),
        .fwd_a_i    (fwd_a),
        .fwd_b_i    (fwd_b),
        .rs1_o      (rs1),
        .rs2_o      (rs2),
        .op_a_o     (op_a),
        .op_b_o     (op_b),
        .alu_op_o   (alu_op),
        .rd_o       (d_rd),
        .we_o       (d_we),
        .pc_o       (d_pc),
        .instr_o    (d_instr)
    );

    alu_stage u_alu (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .d_valid_i  (d_valid),
        .op_a_i     (op_a),
        .op_b_i     (op_b),
        .alu_op_i   (alu_op),
        .rd_i       (d_rd),
        .we_i       (d_we),
        .pc_i       (d_pc),
        .instr_i    (d_instr),
        .e_result_o (e_result),
        .e_rd_o     (e_rd),
        .e_we_o     (e_we),
        .e_pc_o     (e_pc),
        .e_instr_o  (e_instr)
    );

    writeback_regfile u_wb (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .e_valid_i      (e_valid),
        .e_result_i     (e_result),
        .e_rd_i         (e_rd),
        .e_we_i         (e_we),
        .e_pc_i         (e_pc),
        .e_instr_i      (e_instr),
        .ra_i           (rs1),
        .rb_i           (rs2),
        .rf_a_o         (rf_a),
        .rf_b_o         (rf_b),
        .w_result_o     (w_result),
        .w_rd_o         (w_rd),
        .w_we_o         (w_we),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_instr_o (retire_instr_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o)
    );

endmodule

// File: bench/tb_ref.svh
`ifndef TB_REF_SVH
`define TB_REF_SVH

localparam int N_BODY = 200;    // instructions before the ebreak

logic [31:0] lcg_state = 32'h8a6b9e9f;
instr_t      prog [N_BODY + 1];
xlen_t       ref_regs [32];

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// registers kept to x0..x7 so that neighbours depend on each other
function automatic instr_t gen_instr(input int idx);
    logic [31:0] r;
    logic [31:0] v;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    funct3_t     f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    r   = lcg_next();
    v   = lcg_next();
    rd  = {2'b00, r[2:0]};
    rs1 = {2'b00, r[5:3]};
    rs2 = {2'b00, r[8:6]};
    f3  = r[11:9];
    f7  = (r[15] && (f3 == F3_ADD || f3 == F3_SR)) ? 7'h20 : 7'h00;
    imm = v[11:0];
    if (f3 == F3_SLL || f3 == F3_SR) begin
        imm = {1'b0, f7[5], 4'b0000, v[5:0]};   // 6 bit shamt, bit 10 selects srai
    end
    if (idx < 7) begin
        return {v[11:0], 5'd0, F3_ADD, reg_idx_t'(idx + 1), OPC_OP_IMM};  // addi seeds x1..x7
    end
    case (r[14:12])
        3'd0, 3'd1, 3'd2: return {f7, rs2, rs1, f3, rd, OPC_OP};
        3'd3, 3'd4, 3'd5: return {imm, rs1, f3, rd, OPC_OP_IMM};
        3'd6:             return {v[31:12], rd, OPC_LUI};
        default:          return {v[31:7], r[16] ? 7'b1100011 : 7'b0100011};  // branch or store
    endcase
endfunction

// architectural result of one instruction, updates ref_regs
function automatic void ref_step(input instr_t ins, output reg_idx_t rd, output xlen_t data);
    xlen_t      a;
    xlen_t      b;
    xlen_t      res;
    logic [5:0] sh;
    logic       wr;
    a   = ref_regs[ins[19:15]];
    b   = (ins[6:0] == OPC_OP) ? ref_regs[ins[24:20]] : {{52{ins[31]}}, ins[31:20]};
    sh  = b[5:0];
    wr  = 1'b1;
    res = 64'd0;
    if (ins[6:0] == OPC_LUI) begin
        res = {{32{ins[31]}}, ins[31:12], 12'h000};
    end else if (ins[6:0] == OPC_OP || ins[6:0] == OPC_OP_IMM) begin
        case (ins[14:12])
            F3_ADD:  res = (ins[6:0] == OPC_OP && ins[30]) ? a - b : a + b;
            F3_SLL:  res = a << sh;
            F3_SLT:  res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            F3_SLTU: res = (a < b) ? 64'd1 : 64'd0;
            F3_XOR:  res = a ^ b;
            F3_SR:   res = ins[30] ? xlen_t'($signed(a) >>> sh) : a >> sh;
            F3_OR:   res = a | b;
            default: res = a & b;
        endcase
    end else begin
        wr = 1'b0;      // unsupported opcode is a no-op
    end
    if (ins[11:7] == 5'd0) begin
        wr = 1'b0;
    end
    if (wr) begin
        ref_regs[ins[11:7]] = res;
        rd   = ins[11:7];
        data = res;
    end else begin
        rd   = 5'd0;
        data = 64'd0;
    end
endfunction

`endif

// File: bench/tb_rv_alu_core.sv
`timescale 1ns/100ps

module tb_rv_alu_core
    import isa_pkg::*, wb_pkg::*;
();
    localparam pc_t RESET_PC     = 64'h0000_0000_8000_0000;
    localparam int  HALT_TIMEOUT = 20000;
    localparam int  QUIET_CYCLES = 50;

    logic     clk = 1'b0;
    logic     rst_n_i = 1'b0;
    logic     wb_cyc_o;
    logic     wb_stb_o;
    logic     wb_we_o;
    wb_addr_t wb_adr_o;
    wb_data_t wb_dat_i = '0;
    logic     wb_ack_i = 1'b0;
    logic     retire_valid_o;
    pc_t      retire_pc_o;
    instr_t   retire_instr_o;
    reg_idx_t retire_rd_o;
    xlen_t    retire_data_o;
    logic     halt_o;

    int       retired = 0;
    logic     ebreak_retired = 1'b0;
    logic     cyc_last = 1'b0;
    logic     bus_busy = 1'b0;
    int       bus_waits = 0;
    wb_addr_t bus_adr = '0;

    `include "tb_ref.svh"

    rv_alu_core #(
        .RESET_PC (RESET_PC)
    ) uut (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .wb_cyc_o       (wb_cyc_o),
        .wb_stb_o       (wb_stb_o),
        .wb_we_o        (wb_we_o),
        .wb_adr_o       (wb_adr_o),
        .wb_dat_i       (wb_dat_i),
        .wb_ack_i       (wb_ack_i),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_instr_o (retire_instr_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o),
        .halt_o         (halt_o)
    );

    always #10 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_pc(input pc_t got, input pc_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_instr(input instr_t got, input instr_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_reg(input reg_idx_t got, input reg_idx_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s is x%0d, expected x%0d",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_word(input xlen_t got, input xlen_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_addr(input wb_addr_t got, input wb_addr_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s is %b, expected %b",
                                $time, what, got, exp));
        end
    endtask

    function automatic wb_data_t mem_word(input wb_addr_t addr);
        wb_addr_t offset;
        int       idx;
        offset = addr - RESET_PC[31:0];
        idx    = int'(offset >> 2);
        if (offset[1:0] == 2'b00 && offset < wb_addr_t'((N_BODY + 1) * 4)) begin
            return prog[idx];
        end
        return {addr[24:0] ^ addr[31:7], 7'b0000011};   // filler past the ebreak
    endfunction

    // wishbone slave, 0 to 3 wait states per read
    always @(posedge clk) begin
        #1;
        wb_ack_i = 1'b0;
        if (!rst_n_i) begin
            bus_busy = 1'b0;
        end else if (bus_busy || (wb_cyc_o && wb_stb_o)) begin
            if (!bus_busy) begin
                bus_busy  = 1'b1;
                bus_adr   = wb_adr_o;
                bus_waits = int'(lcg_next() >> 30);
            end
            check_bit(wb_cyc_o, 1'b1, "wb_cyc_o before ack");
            check_bit(wb_stb_o, 1'b1, "wb_stb_o before ack");
            check_addr(wb_adr_o, bus_adr, "wb_adr_o before ack");
            if (bus_waits == 0) begin
                wb_dat_i = mem_word(wb_adr_o);
                wb_ack_i = 1'b1;
                bus_busy = 1'b0;
            end else begin
                bus_waits = bus_waits - 1;
            end
        end
    end

    always @(negedge clk) begin
        reg_idx_t exp_rd;
        xlen_t    exp_data;
        pc_t      exp_pc;
        if (ebreak_retired && wb_cyc_o && !cyc_last) begin
            abort_run("A new Wishbone cycle started after the ebreak retired");
        end
        cyc_last = wb_cyc_o;
        if (wb_cyc_o) begin
            check_bit(wb_we_o, 1'b0, "wb_we_o");
        end else begin
            check_bit(wb_stb_o, 1'b0, "wb_stb_o outside a bus cycle");
        end
        if (rst_n_i && retire_valid_o) begin
            if (ebreak_retired) begin
                abort_run("An instruction retired after the ebreak");
            end
            exp_pc = RESET_PC + 64'(retired * 4);
            check_pc(retire_pc_o, exp_pc, "retire_pc_o");
            check_instr(retire_instr_o, mem_word(exp_pc[31:0]), "retire_instr_o");
            if (retired < N_BODY) begin
                ref_step(prog[retired], exp_rd, exp_data);
                check_bit(halt_o, 1'b0, "halt_o before ebreak");
            end else begin
                exp_rd   = 5'd0;
                exp_data = 64'd0;
                check_bit(halt_o, 1'b1, "halt_o at ebreak");
                ebreak_retired = 1'b1;
            end
            check_reg(retire_rd_o, exp_rd, "retire_rd_o");
            check_word(retire_data_o, exp_data, "retire_data_o");
            retired = retired + 1;
        end
    end

    initial begin
        int cycles;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        for (int i = 0; i <= N_BODY; i++) begin
            prog[i] = (i == N_BODY) ? INSTR_EBREAK : gen_instr(i);
        end
        repeat (10) begin
            @(negedge clk);
            check_bit(wb_cyc_o, 1'b0, "wb_cyc_o in reset");
            check_bit(retire_valid_o, 1'b0, "retire_valid_o in reset");
            check_bit(halt_o, 1'b0, "halt_o in reset");
        end
        @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        @(negedge clk);
        check_bit(wb_cyc_o, 1'b0, "wb_cyc_o after reset");
        check_bit(retire_valid_o, 1'b0, "retire_valid_o after reset");
        check_bit(halt_o, 1'b0, "halt_o after reset");
        @(negedge clk);
        check_bit(wb_cyc_o, 1'b1, "wb_cyc_o in the first cycle after reset");
        cycles = 0;
        while (!ebreak_retired) begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles > HALT_TIMEOUT) begin
                abort_run("Timeout: the ebreak did not retire in time");
            end
        end
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            @(negedge clk);
            check_bit(halt_o, 1'b1, "halt_o after ebreak");
        end
        @(posedge clk);
        #1;
        if (!wb_cyc_o) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            abort_run("The last Wishbone cycle did not close after the ebreak");
        end
    end

endmodule

// File: rv_alu_core.f
+incdir+bench
rtl/isa_pkg.sv
rtl/wb_pkg.sv
rtl/fetch_unit.sv
rtl/pipeline_ctrl.sv
rtl/decode_stage.sv
rtl/alu_stage.sv
rtl/writeback_regfile.sv
rtl/rv_alu_core.sv
bench/tb_rv_alu_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_rv_alu_core
FILELIST  := rv_alu_core.f
VFLAGS    := --binary --timing --top-module $(TOP)
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Simulation completed successfully
SOURCES   := $(wildcard rtl/*.sv bench/*.sv bench/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
